// File: ppu_pkg.sv
package ppu_pkg;

  // bus widths
  parameter int ADDR_W = 32;
  parameter int DATA_W = 32;
  parameter int BE_W   = DATA_W / 8;

  // address map, bounds are inclusive
  parameter logic [ADDR_W-1:0] IRAM_START = 32'h0000_0000;
  parameter logic [ADDR_W-1:0] IRAM_END   = 32'h000F_FFFF;
  parameter logic [ADDR_W-1:0] DRAM_START = 32'h3000_0000;
  parameter logic [ADDR_W-1:0] DRAM_END   = 32'h3000_FFFF;
  parameter logic [ADDR_W-1:0] GPIO_START = 32'h1A10_0000;
  parameter logic [ADDR_W-1:0] GPIO_END   = 32'h1A11_FFFF;

  // gpio register indices, word granular
  parameter logic [3:0] GPIO_REG_OUT = 4'd0;
  parameter logic [3:0] GPIO_REG_DIR = 4'd1;
  parameter logic [3:0] GPIO_REG_IN  = 4'd2;

  // target of a decoded access
  typedef enum logic [1:0] {
    SEL_IRAM,
    SEL_DRAM,
    SEL_GPIO,
    SEL_NONE
  } slave_sel_e;

  // one address word, seen either by a ram or by a register block
  typedef union packed {
    struct packed {
      logic [19:0] high;
      logic [9:0]  word_idx;
      logic [1:0]  byte_off;
    } ram;
    struct packed {
      logic [19:0] high;
      logic [5:0]  unused;
      logic [3:0]  reg_idx;
      logic [1:0]  byte_off;
    } regs;
  } bus_addr_u;

endpackage

// File: sram_bank.sv
`timescale 1ns/1ps

module sram_bank #(
  parameter int WORDS = 256
) (
  input  logic                       clk_i,
  input  logic                       sel_i,
  input  logic                       we_i,
  input  logic [ppu_pkg::BE_W-1:0]   be_i,
  input  ppu_pkg::bus_addr_u         addr_i,
  input  logic [ppu_pkg::DATA_W-1:0] wdata_i,
  output logic [ppu_pkg::DATA_W-1:0] rdata_o
);

  localparam int IDX_W = $clog2(WORDS);

  logic [ppu_pkg::DATA_W-1:0] mem [WORDS];
  logic [IDX_W-1:0]           idx;

  // only the low index bits address the array
  assign idx = addr_i.ram.word_idx[IDX_W-1:0];

  always_ff @(posedge clk_i) begin
    if (sel_i && we_i) begin
      for (int b = 0; b < ppu_pkg::BE_W; b++) begin
        if (be_i[b]) begin
          mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // registered read, old word on a write
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rdata_o <= mem[idx];
    end
  end

  // index must not alias into a smaller array
  word_idx_range_a: assert property (@(posedge clk_i)
    sel_i |-> (32'(addr_i.ram.word_idx) < WORDS));

endmodule

// File: gpio_regs.sv
`timescale 1ns/1ps

module gpio_regs (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       sel_i,
  input  logic                       we_i,
  input  logic [ppu_pkg::BE_W-1:0]   be_i,
  input  ppu_pkg::bus_addr_u         addr_i,
  input  logic [ppu_pkg::DATA_W-1:0] wdata_i,
  output logic [ppu_pkg::DATA_W-1:0] rdata_o,
  input  logic [ppu_pkg::DATA_W-1:0] gpio_in_i,
  output logic [ppu_pkg::DATA_W-1:0] gpio_out_o,
  output logic [ppu_pkg::DATA_W-1:0] gpio_dir_o
);

  logic [ppu_pkg::DATA_W-1:0] out_q;
  logic [ppu_pkg::DATA_W-1:0] dir_q;
  logic [ppu_pkg::DATA_W-1:0] in_meta_q;
  logic [ppu_pkg::DATA_W-1:0] in_sync_q;
  logic                       wr_out;
  logic                       wr_dir;

  assign wr_out = sel_i && we_i && (addr_i.regs.reg_idx == ppu_pkg::GPIO_REG_OUT);
  assign wr_dir = sel_i && we_i && (addr_i.regs.reg_idx == ppu_pkg::GPIO_REG_DIR);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_q <= '0;
      dir_q <= '0;
    end else begin
      for (int b = 0; b < ppu_pkg::BE_W; b++) begin
        if (wr_out && be_i[b]) begin
          out_q[8*b +: 8] <= wdata_i[8*b +: 8];
        end
        if (wr_dir && be_i[b]) begin
          dir_q[8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // two flop synchroniser on the pins
  always_ff @(posedge clk_i) begin
    in_meta_q <= gpio_in_i;
    in_sync_q <= in_meta_q;
  end

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      case (addr_i.regs.reg_idx)
        ppu_pkg::GPIO_REG_OUT: rdata_o <= out_q;
        ppu_pkg::GPIO_REG_DIR: rdata_o <= dir_q;
        ppu_pkg::GPIO_REG_IN:  rdata_o <= in_sync_q;
        default:               rdata_o <= '0;
      endcase
    end
  end

  assign gpio_out_o = out_q;
  assign gpio_dir_o = dir_q;

endmodule

// File: bus_node.sv
`timescale 1ns/1ps

module bus_node (
  input  logic                       clk_i,
  input  logic                       reset_i,

  // core master
  input  logic                       core_req_i,
  input  logic [ppu_pkg::ADDR_W-1:0] core_addr_i,
  input  logic                       core_we_i,
  input  logic [ppu_pkg::BE_W-1:0]   core_be_i,
  input  logic [ppu_pkg::DATA_W-1:0] core_wdata_i,
  output logic                       core_done_o,
  output logic                       core_err_o,
  output logic [ppu_pkg::DATA_W-1:0] core_rdata_o,

  // debug master
  input  logic                       dbg_req_i,
  input  logic [ppu_pkg::ADDR_W-1:0] dbg_addr_i,
  input  logic                       dbg_we_i,
  input  logic [ppu_pkg::BE_W-1:0]   dbg_be_i,
  input  logic [ppu_pkg::DATA_W-1:0] dbg_wdata_i,
  output logic                       dbg_done_o,
  output logic                       dbg_err_o,
  output logic [ppu_pkg::DATA_W-1:0] dbg_rdata_o,

  // slave side
  output logic                       iram_sel_o,
  output logic                       dram_sel_o,
  output logic                       gpio_sel_o,
  output logic [ppu_pkg::ADDR_W-1:0] slv_addr_o,
  output logic                       slv_we_o,
  output logic [ppu_pkg::BE_W-1:0]   slv_be_o,
  output logic [ppu_pkg::DATA_W-1:0] slv_wdata_o,
  input  logic [ppu_pkg::DATA_W-1:0] iram_rdata_i,
  input  logic [ppu_pkg::DATA_W-1:0] dram_rdata_i,
  input  logic [ppu_pkg::DATA_W-1:0] gpio_rdata_i
);

  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_ACCESS  = 2'd1;
  localparam logic [1:0] ST_RESPOND = 2'd2;

  logic [1:0]                 state_q;
  logic                       rr_dbg_q;
  logic                       gnt_dbg_q;
  ppu_pkg::slave_sel_e        target_q;
  logic [ppu_pkg::ADDR_W-1:0] addr_q;
  logic                       we_q;
  logic [ppu_pkg::BE_W-1:0]   be_q;
  logic [ppu_pkg::DATA_W-1:0] wdata_q;

  logic                       accept;
  logic                       pick_dbg;
  logic [ppu_pkg::ADDR_W-1:0] req_addr;
  ppu_pkg::slave_sel_e        req_target;
  logic [ppu_pkg::DATA_W-1:0] resp_data;
  logic                       resp_valid;
  logic                       resp_err;

  function automatic ppu_pkg::slave_sel_e decode(input logic [ppu_pkg::ADDR_W-1:0] addr);
    if (addr >= ppu_pkg::IRAM_START && addr <= ppu_pkg::IRAM_END)
      return ppu_pkg::SEL_IRAM;
    if (addr >= ppu_pkg::DRAM_START && addr <= ppu_pkg::DRAM_END)
      return ppu_pkg::SEL_DRAM;
    if (addr >= ppu_pkg::GPIO_START && addr <= ppu_pkg::GPIO_END)
      return ppu_pkg::SEL_GPIO;
    return ppu_pkg::SEL_NONE;
  endfunction

  // round robin pointer only matters on contention
  assign pick_dbg   = (core_req_i && dbg_req_i) ? rr_dbg_q : dbg_req_i;
  assign accept     = (state_q == ST_IDLE) && (core_req_i || dbg_req_i);
  assign req_addr   = pick_dbg ? dbg_addr_i : core_addr_i;
  assign req_target = decode(req_addr);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= ST_IDLE;
      rr_dbg_q  <= 1'b0;
      gnt_dbg_q <= 1'b0;
      target_q  <= ppu_pkg::SEL_NONE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            state_q   <= ST_ACCESS;
            gnt_dbg_q <= pick_dbg;
            // hand priority to the other master
            rr_dbg_q  <= ~pick_dbg;
            target_q  <= req_target;
          end
        end
        ST_ACCESS: state_q <= ST_RESPOND;
        default:   state_q <= ST_IDLE;
      endcase
    end
  end

  // request payload of the granted master
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= req_addr;
      we_q    <= pick_dbg ? dbg_we_i : core_we_i;
      be_q    <= pick_dbg ? dbg_be_i : core_be_i;
      wdata_q <= pick_dbg ? dbg_wdata_i : core_wdata_i;
    end
  end

  assign iram_sel_o  = (state_q == ST_ACCESS) && (target_q == ppu_pkg::SEL_IRAM);
  assign dram_sel_o  = (state_q == ST_ACCESS) && (target_q == ppu_pkg::SEL_DRAM);
  assign gpio_sel_o  = (state_q == ST_ACCESS) && (target_q == ppu_pkg::SEL_GPIO);
  assign slv_addr_o  = addr_q;
  assign slv_we_o    = we_q;
  assign slv_be_o    = be_q;
  assign slv_wdata_o = wdata_q;

  // unmapped target reads as zero
  always_comb begin
    case (target_q)
      ppu_pkg::SEL_IRAM: resp_data = iram_rdata_i;
      ppu_pkg::SEL_DRAM: resp_data = dram_rdata_i;
      ppu_pkg::SEL_GPIO: resp_data = gpio_rdata_i;
      default:           resp_data = '0;
    endcase
  end

  assign resp_valid = (state_q == ST_RESPOND);
  assign resp_err   = resp_valid && (target_q == ppu_pkg::SEL_NONE);

  assign core_done_o  = resp_valid && !gnt_dbg_q;
  assign core_err_o   = resp_err && !gnt_dbg_q;
  assign core_rdata_o = resp_data;
  assign dbg_done_o   = resp_valid && gnt_dbg_q;
  assign dbg_err_o    = resp_err && gnt_dbg_q;
  assign dbg_rdata_o  = resp_data;

  sel_onehot_a: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0({iram_sel_o, dram_sel_o, gpio_sel_o}));

  done_single_a: assert property (@(posedge clk_i) disable iff (reset_i)
    !(core_done_o && dbg_done_o));

endmodule

// File: ppu_top.sv
`timescale 1ns/1ps

module ppu_top #(
  parameter int IRAM_WORDS = 256,
  parameter int DRAM_WORDS = 256
) (
  input  logic                       clk_i,
  input  logic                       reset_i,

  // core master
  input  logic                       core_req_i,
  input  logic [ppu_pkg::ADDR_W-1:0] core_addr_i,
  input  logic                       core_we_i,
  input  logic [ppu_pkg::BE_W-1:0]   core_be_i,
  input  logic [ppu_pkg::DATA_W-1:0] core_wdata_i,
  output logic                       core_done_o,
  output logic                       core_err_o,
  output logic [ppu_pkg::DATA_W-1:0] core_rdata_o,

  // debug master
  input  logic                       dbg_req_i,
  input  logic [ppu_pkg::ADDR_W-1:0] dbg_addr_i,
  input  logic                       dbg_we_i,
  input  logic [ppu_pkg::BE_W-1:0]   dbg_be_i,
  input  logic [ppu_pkg::DATA_W-1:0] dbg_wdata_i,
  output logic                       dbg_done_o,
  output logic                       dbg_err_o,
  output logic [ppu_pkg::DATA_W-1:0] dbg_rdata_o,

  // gpio pins
  input  logic [ppu_pkg::DATA_W-1:0] gpio_in_i,
  output logic [ppu_pkg::DATA_W-1:0] gpio_out_o,
  output logic [ppu_pkg::DATA_W-1:0] gpio_dir_o
);

  logic                       iram_sel;
  logic                       dram_sel;
  logic                       gpio_sel;
  logic [ppu_pkg::ADDR_W-1:0] slv_addr;
  logic                       slv_we;
  logic [ppu_pkg::BE_W-1:0]   slv_be;
  logic [ppu_pkg::DATA_W-1:0] slv_wdata;
  logic [ppu_pkg::DATA_W-1:0] iram_rdata;
  logic [ppu_pkg::DATA_W-1:0] dram_rdata;
  logic [ppu_pkg::DATA_W-1:0] gpio_rdata;

  bus_node node_i (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .core_req_i   ( core_req_i   ),
    .core_addr_i  ( core_addr_i  ),
    .core_we_i    ( core_we_i    ),
    .core_be_i    ( core_be_i    ),
    .core_wdata_i ( core_wdata_i ),
    .core_done_o  ( core_done_o  ),
    .core_err_o   ( core_err_o   ),
    .core_rdata_o ( core_rdata_o ),
    .dbg_req_i    ( dbg_req_i    ),
    .dbg_addr_i   ( dbg_addr_i   ),
    .dbg_we_i     ( dbg_we_i     ),
    .dbg_be_i     ( dbg_be_i     ),
    .dbg_wdata_i  ( dbg_wdata_i  ),
    .dbg_done_o   ( dbg_done_o   ),
    .dbg_err_o    ( dbg_err_o    ),
    .dbg_rdata_o  ( dbg_rdata_o  ),
    .iram_sel_o   ( iram_sel     ),
    .dram_sel_o   ( dram_sel     ),
    .gpio_sel_o   ( gpio_sel     ),
    .slv_addr_o   ( slv_addr     ),
    .slv_we_o     ( slv_we       ),
    .slv_be_o     ( slv_be       ),
    .slv_wdata_o  ( slv_wdata    ),
    .iram_rdata_i ( iram_rdata   ),
    .dram_rdata_i ( dram_rdata   ),
    .gpio_rdata_i ( gpio_rdata   )
  );

  // instruction memory
  sram_bank #(
    .WORDS ( IRAM_WORDS )
  ) iram_i (
    .clk_i   ( clk_i      ),
    .sel_i   ( iram_sel   ),
    .we_i    ( slv_we     ),
    .be_i    ( slv_be     ),
    .addr_i  ( slv_addr   ),
    .wdata_i ( slv_wdata  ),
    .rdata_o ( iram_rdata )
  );

  // data memory
  sram_bank #(
    .WORDS ( DRAM_WORDS )
  ) dram_i (
    .clk_i   ( clk_i      ),
    .sel_i   ( dram_sel   ),
    .we_i    ( slv_we     ),
    .be_i    ( slv_be     ),
    .addr_i  ( slv_addr   ),
    .wdata_i ( slv_wdata  ),
    .rdata_o ( dram_rdata )
  );

  gpio_regs gpio_i (
    .clk_i      ( clk_i      ),
    .reset_i    ( reset_i    ),
    .sel_i      ( gpio_sel   ),
    .we_i       ( slv_we     ),
    .be_i       ( slv_be     ),
    .addr_i     ( slv_addr   ),
    .wdata_i    ( slv_wdata  ),
    .rdata_o    ( gpio_rdata ),
    .gpio_in_i  ( gpio_in_i  ),
    .gpio_out_o ( gpio_out_o ),
    .gpio_dir_o ( gpio_dir_o )
  );

endmodule

// File: tb_ppu_top.sv
`timescale 1ns/1ps

module tb_ppu_top;

  // one edge to accept the request and two more cycles to done
  localparam int REQ_TO_DONE = 3;
  // about 55 accesses of 4 to 7 cycles each plus a wide margin
  localparam int MAX_CYCLES  = 2000;
  localparam logic [9:0] IRAM_OFFS [4] = '{10'h000, 10'h004, 10'h1f0, 10'h3fc};
  localparam logic [9:0] DRAM_OFFS [4] = '{10'h000, 10'h080, 10'h204, 10'h3f8};
  localparam logic [3:0] BE_LIST [5]   = '{4'b0001, 4'b0110, 4'b1000, 4'b1010, 4'b0000};

  logic        clk = 1'b0;
  logic        reset;
  logic        core_req, core_we, core_done, core_err;
  logic [31:0] core_addr, core_wdata, core_rdata;
  logic [3:0]  core_be;
  logic        dbg_req, dbg_we, dbg_done, dbg_err;
  logic [31:0] dbg_addr, dbg_wdata, dbg_rdata;
  logic [3:0]  dbg_be;
  logic [31:0] gpio_in, gpio_out, gpio_dir;

  // reference state
  logic [31:0] iram_model [256];
  logic [31:0] dram_model [256];
  logic [31:0] out_model;
  logic [31:0] dir_model;

  string test_name;
  int    n_checks = 0;
  int    n_errors = 0;
  int    cycles = 0;
  int    core_done_cnt = 0;
  int    dbg_done_cnt = 0;
  int    last_lat [2];

  ppu_top #(.IRAM_WORDS(256), .DRAM_WORDS(256)) dut_i (
    .clk_i(clk), .reset_i(reset),
    .core_req_i(core_req), .core_addr_i(core_addr), .core_we_i(core_we),
    .core_be_i(core_be), .core_wdata_i(core_wdata), .core_done_o(core_done),
    .core_err_o(core_err), .core_rdata_o(core_rdata),
    .dbg_req_i(dbg_req), .dbg_addr_i(dbg_addr), .dbg_we_i(dbg_we),
    .dbg_be_i(dbg_be), .dbg_wdata_i(dbg_wdata), .dbg_done_o(dbg_done),
    .dbg_err_o(dbg_err), .dbg_rdata_o(dbg_rdata),
    .gpio_in_i(gpio_in), .gpio_out_o(gpio_out), .gpio_dir_o(gpio_dir)
  );

  always #10 clk = ~clk;

  // done pulses seen per master
  always @(negedge clk) begin
    if (core_done) core_done_cnt++;
    if (dbg_done) dbg_done_cnt++;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles without finishing", cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0] be);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  function automatic logic [31:0] gpio_addr(input logic [3:0] idx);
    return ppu_pkg::GPIO_START + {26'd0, idx, 2'b00};
  endfunction

  task automatic apply_reset();
    reset <= 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
  endtask

  // one access on the chosen master held until its done pulse
  task automatic bus_access(input bit dbg, input bit we, input logic [31:0] addr,
                            input logic [3:0] be, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int lat;
    @(posedge clk);
    if (dbg) begin
      dbg_req <= 1'b1;
      dbg_we <= we;
      dbg_addr <= addr;
      dbg_be <= be;
      dbg_wdata <= wdata;
    end else begin
      core_req <= 1'b1;
      core_we <= we;
      core_addr <= addr;
      core_be <= be;
      core_wdata <= wdata;
    end
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!(dbg ? dbg_done : core_done));
    rdata = dbg ? dbg_rdata : core_rdata;
    err = dbg ? dbg_err : core_err;
    last_lat[dbg] = lat;
    @(posedge clk);
    if (dbg) dbg_req <= 1'b0;
    else core_req <= 1'b0;
  endtask

  task automatic bus_write(input bit dbg, input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] be, output logic err);
    logic [31:0] unused_rd;
    bus_access(dbg, 1'b1, addr, be, data, unused_rd, err);
  endtask

  task automatic bus_read(input bit dbg, input logic [31:0] addr,
                          output logic [31:0] rdata, output logic err);
    bus_access(dbg, 1'b0, addr, 4'hf, 32'd0, rdata, err);
  endtask

  task automatic ram_write(input bit dbg, input bit dram, input logic [9:0] off,
                           input logic [31:0] data, input logic [3:0] be);
    logic [31:0] base;
    logic        err;
    base = dram ? ppu_pkg::DRAM_START : ppu_pkg::IRAM_START;
    bus_write(dbg, base + {22'd0, off}, data, be, err);
    check("write err", 32'd0, 32'(err));
    if (dram) dram_model[off[9:2]] = merge_bytes(dram_model[off[9:2]], data, be);
    else iram_model[off[9:2]] = merge_bytes(iram_model[off[9:2]], data, be);
  endtask

  task automatic ram_check(input bit dbg, input bit dram, input logic [9:0] off);
    logic [31:0] base;
    logic [31:0] rd;
    logic        err;
    base = dram ? ppu_pkg::DRAM_START : ppu_pkg::IRAM_START;
    bus_read(dbg, base + {22'd0, off}, rd, err);
    check("read err", 32'd0, 32'(err));
    check("read data", dram ? dram_model[off[9:2]] : iram_model[off[9:2]], rd);
  endtask

  task automatic reg_write(input bit dbg, input logic [3:0] idx, input logic [31:0] data,
                           input logic [3:0] be);
    logic err;
    bus_write(dbg, gpio_addr(idx), data, be, err);
    check("reg write err", 32'd0, 32'(err));
  endtask

  task automatic reg_check(input bit dbg, input logic [3:0] idx, input logic [31:0] exp);
    logic [31:0] rd;
    logic        err;
    bus_read(dbg, gpio_addr(idx), rd, err);
    check("reg read err", 32'd0, 32'(err));
    check("reg read data", exp, rd);
  endtask

  task automatic test_reset_and_latency();
    test_name = "reset";
    @(negedge clk);
    check("core done", 32'd0, 32'(core_done));
    check("dbg done", 32'd0, 32'(dbg_done));
    check("core err", 32'd0, 32'(core_err));
    check("dbg err", 32'd0, 32'(dbg_err));
    check("gpio out", 32'd0, gpio_out);
    check("gpio dir", 32'd0, gpio_dir);
    ram_write(1'b0, 1'b0, 10'h010, $urandom, 4'hf);
    check("done latency", 32'(REQ_TO_DONE), 32'(last_lat[0]));
  endtask

  task automatic test_ram_words();
    test_name = "ram_words";
    for (int i = 0; i < 4; i++) begin
      ram_write(i[0], 1'b0, IRAM_OFFS[i], $urandom, 4'hf);
      ram_write(!i[0], 1'b1, DRAM_OFFS[i], $urandom, 4'hf);
    end
    for (int i = 0; i < 4; i++) begin
      ram_check(1'b0, 1'b0, IRAM_OFFS[i]);
      ram_check(1'b1, 1'b0, IRAM_OFFS[i]);
      ram_check(1'b0, 1'b1, DRAM_OFFS[i]);
      ram_check(1'b1, 1'b1, DRAM_OFFS[i]);
    end
  endtask

  task automatic test_byte_enables();
    test_name = "byte_enables";
    ram_write(1'b0, 1'b1, 10'h100, $urandom, 4'hf);
    for (int i = 0; i < 5; i++) begin
      ram_write(i[0], 1'b1, 10'h100, $urandom, BE_LIST[i]);
      ram_check(!i[0], 1'b1, 10'h100);
    end
  endtask

  task automatic test_gpio();
    logic [31:0] pins;
    test_name = "gpio";
    out_model = $urandom;
    reg_write(1'b0, ppu_pkg::GPIO_REG_OUT, out_model, 4'hf);
    dir_model = $urandom;
    reg_write(1'b1, ppu_pkg::GPIO_REG_DIR, dir_model, 4'hf);
    pins = $urandom;
    reg_write(1'b0, ppu_pkg::GPIO_REG_DIR, pins, 4'b0011);
    dir_model = merge_bytes(dir_model, pins, 4'b0011);
    @(negedge clk);
    check("out pins", out_model, gpio_out);
    check("dir pins", dir_model, gpio_dir);
    reg_check(1'b1, ppu_pkg::GPIO_REG_OUT, out_model);
    reg_check(1'b0, ppu_pkg::GPIO_REG_DIR, dir_model);
    pins = $urandom;
    @(posedge clk);
    gpio_in <= pins;
    // let the synchroniser settle
    repeat (3) @(posedge clk);
    reg_check(1'b0, ppu_pkg::GPIO_REG_IN, pins);
    reg_write(1'b1, ppu_pkg::GPIO_REG_IN, ~pins, 4'hf);
    reg_check(1'b1, ppu_pkg::GPIO_REG_IN, pins);
    reg_check(1'b0, 4'd3, 32'd0);
    check("out after in write", out_model, gpio_out);
    check("dir after in write", dir_model, gpio_dir);
  endtask

  task automatic test_unmapped();
    logic [31:0] rd;
    logic        err;
    test_name = "unmapped";
    bus_read(1'b0, 32'h2000_0000, rd, err);
    check("read err", 32'd1, 32'(err));
    check("read data", 32'd0, rd);
    bus_write(1'b1, 32'h2000_0000, $urandom, 4'hf, err);
    check("write err", 32'd1, 32'(err));
    bus_write(1'b0, ppu_pkg::DRAM_END + 32'd1, $urandom, 4'hf, err);
    check("past dram err", 32'd1, 32'(err));
    ram_check(1'b0, 1'b0, 10'h000);
    ram_check(1'b1, 1'b1, 10'h000);
  endtask

  task automatic test_contention();
    int core_before;
    int dbg_before;
    test_name = "contention";
    apply_reset();
    out_model = '0;
    dir_model = '0;
    // gpio registers held values from the gpio test
    @(negedge clk);
    check("out after reset", out_model, gpio_out);
    check("dir after reset", dir_model, gpio_dir);
    core_before = core_done_cnt;
    dbg_before = dbg_done_cnt;
    fork
      ram_write(1'b0, 1'b1, 10'h040, $urandom, 4'hf);
      ram_write(1'b1, 1'b1, 10'h044, $urandom, 4'hf);
    join
    // core wins first after reset and dbg waits one full access
    check("core latency", 32'(REQ_TO_DONE), 32'(last_lat[0]));
    check("dbg latency", 32'(2 * REQ_TO_DONE), 32'(last_lat[1]));
    check("core done count", 32'(core_before + 1), 32'(core_done_cnt));
    check("dbg done count", 32'(dbg_before + 1), 32'(dbg_done_cnt));
    fork
      ram_check(1'b0, 1'b1, 10'h044);
      ram_check(1'b1, 1'b1, 10'h040);
    join
  endtask

  initial begin
    void'($urandom(32'hd63a4afc));
    reset = 1'b1;
    core_req = 1'b0;
    core_we = 1'b0;
    core_addr = '0;
    core_be = '0;
    core_wdata = '0;
    dbg_req = 1'b0;
    dbg_we = 1'b0;
    dbg_addr = '0;
    dbg_be = '0;
    dbg_wdata = '0;
    gpio_in = '0;
    apply_reset();
    test_reset_and_latency();
    test_ram_words();
    test_byte_enables();
    test_gpio();
    test_unmapped();
    test_contention();
    $display("checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: tb.f
ppu_pkg.sv
sram_bank.sv
gpio_regs.sv
bus_node.sv
ppu_top.sv
tb_ppu_top.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_ppu_top -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed" sim.log; then
  exit 0
fi
echo "simulation reported a failure, see sim.log"
exit 1
